// File: project.f
+incdir+source
+incdir+tb
source/conv_cfg_pkg.sv
source/conv_data_pkg.sv
source/quant_param_table.sv
source/row_sequencer.sv
source/requant_lane.sv
source/conv_datapath.sv
tb/conv_datapath_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the conv_datapath testbench with Verilator and runs it
# exit status is the simulator's own status

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
    --top-module conv_datapath_tb \
    --Mdir obj_dir -o conv_datapath_tb \
    -f project.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/conv_datapath_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation ended with status $sim_status"
    exit $sim_status
fi

exit 0

// File: source/conv_cfg_pkg.sv
`include "conv_defines.svh"

package conv_cfg_pkg;

    // precision of the weights behind the partial sums
    typedef enum logic {
        MODE_W8 = 1'b0,
        MODE_W1 = 1'b1
    } quant_mode_t;

    // row sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_RUN   = 2'd1,
        SEQ_DRAIN = 2'd2
    } seq_state_t;

    // channel of a row, wraps at CONV_CHANNELS
    typedef logic [`CONV_CHAN_W-1:0] chan_idx_t;

    // row number inside a tile
    typedef logic [`CONV_ROW_W-1:0] row_idx_t;

    // sampled with the start strobe
    // row_count must be nonzero
    typedef struct packed {
        quant_mode_t mode;
        row_idx_t    row_count;
    } tile_cfg_t;

endpackage

// File: source/conv_data_pkg.sv
`include "conv_defines.svh"

package conv_data_pkg;

    //////////////////////////////
    // per lane
    //////////////////////////////

    // one 24-bit value or two 12-bit halves
    typedef logic [23:0] psum_lane_t;

    // W8 result in low byte, W1 sub-channel 1 in high byte
    typedef logic [15:0] qpix_lane_t;

    //////////////////////////////
    // per channel parameter sets
    //////////////////////////////

    // W8 uses all 16 bits, W1 one signed byte per sub-channel
    typedef logic [15:0] bias_set_t;
    // unsigned multipliers, W8 uses the low half
    typedef logic [31:0] tail_set_t;
    // shift amount in low 5 bits of each byte
    typedef logic [15:0] rank_set_t;

    typedef struct packed {
        bias_set_t bias;
        tail_set_t tail;
        rank_set_t rank;
    } quant_param_t;

    // whole tiles, channel 0 in the lowest bits
    typedef bias_set_t [`CONV_CHANNELS-1:0] bias_tile_t;
    typedef tail_set_t [`CONV_CHANNELS-1:0] tail_tile_t;
    typedef rank_set_t [`CONV_CHANNELS-1:0] rank_tile_t;

    //////////////////////////////
    // rows
    //////////////////////////////

    typedef psum_lane_t [`CONV_LANES-1:0] psum_row_t;
    typedef qpix_lane_t [`CONV_LANES-1:0] qpix_row_t;

    // result row tagged with its position in the tile
    typedef struct packed {
        conv_cfg_pkg::row_idx_t  row;
        conv_cfg_pkg::chan_idx_t chan;
        qpix_row_t               pix;
    } out_row_t;

endpackage

// File: source/conv_datapath.sv
`timescale 1ns/1ns
`include "conv_defines.svh"

module conv_datapath (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  conv_cfg_pkg::tile_cfg_t   cfg,
    input  conv_data_pkg::bias_tile_t bias_tile,
    input  conv_data_pkg::tail_tile_t tail_tile,
    input  conv_data_pkg::rank_tile_t rank_tile,
    input  logic                      psum_valid,
    input  conv_data_pkg::psum_row_t  psum_row,
    output logic                      out_valid,
    output conv_data_pkg::out_row_t   out_row,
    output logic                      busy,
    output logic                      done
);

    import conv_cfg_pkg::*;
    import conv_data_pkg::*;

    logic         load;
    logic         row_accept;
    chan_idx_t    cur_chan;
    quant_mode_t  mode;
    quant_param_t param;
    row_idx_t     out_row_idx;
    chan_idx_t    out_chan;
    qpix_row_t    qpix_row;

    //////////////////////////////
    // control
    //////////////////////////////

    quant_param_table u_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .bias_tile (bias_tile),
        .tail_tile (tail_tile),
        .rank_tile (rank_tile),
        .chan      (cur_chan),
        .param     (param)
    );

    row_sequencer u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .cfg           (cfg),
        .psum_valid    (psum_valid),
        .load          (load),
        .row_accept    (row_accept),
        .cur_chan      (cur_chan),
        .mode          (mode),
        .out_tag_valid (out_valid),
        .out_row_idx   (out_row_idx),
        .out_chan      (out_chan),
        .busy          (busy),
        .done          (done)
    );

    //////////////////////////////
    // lanes
    //////////////////////////////

    // all lanes share one channel's parameters
    for (genvar i = 0; i < `CONV_LANES; i++) begin : g_lane
        requant_lane u_lane (
            .clk      (clk),
            .rst_n    (rst_n),
            .in_valid (row_accept),
            .mode     (mode),
            .psum     (psum_row[i]),
            .param    (param),
            .qpix     (qpix_row[i])
        );
    end

    // tags were delayed to match lane latency
    assign out_row = '{row: out_row_idx, chan: out_chan, pix: qpix_row};

endmodule

// File: source/conv_defines.svh
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

//////////////////////////////
// array geometry
//////////////////////////////

// lanes per partial-sum row
`define CONV_LANES 4

// output channels held in one parameter tile
`define CONV_CHANNELS 8

//////////////////////////////
// counter widths
//////////////////////////////

// wide enough for CONV_CHANNELS
`define CONV_CHAN_W 3

// rows per tile, up to 255
`define CONV_ROW_W 8

`endif

// File: source/quant_param_table.sv
`timescale 1ns/1ns

module quant_param_table (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load,
    input  conv_data_pkg::bias_tile_t   bias_tile,
    input  conv_data_pkg::tail_tile_t   tail_tile,
    input  conv_data_pkg::rank_tile_t   rank_tile,
    input  conv_cfg_pkg::chan_idx_t     chan,
    output conv_data_pkg::quant_param_t param
);

    import conv_data_pkg::*;

    //////////////////////////////
    // tile storage
    //////////////////////////////

    // one set per channel, held for the whole tile
    bias_tile_t bias_q;
    tail_tile_t tail_q;
    rank_tile_t rank_q;

    // written only on an accepted start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bias_q <= '0;
            tail_q <= '0;
            rank_q <= '0;
        end else if (load) begin
            bias_q <= bias_tile;
            tail_q <= tail_tile;
            rank_q <= rank_tile;
        end
    end

    //////////////////////////////
    // channel select
    //////////////////////////////

    // combinational lookup for the channel of the current row
    // lanes register the result together with the psum
    assign param = '{
        bias: bias_q[chan],
        tail: tail_q[chan],
        rank: rank_q[chan]
    };

endmodule

// File: source/requant_lane.sv
`timescale 1ns/1ns

module requant_lane (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  conv_cfg_pkg::quant_mode_t   mode,
    input  conv_data_pkg::psum_lane_t   psum,
    input  conv_data_pkg::quant_param_t param,
    output conv_data_pkg::qpix_lane_t   qpix
);

    import conv_cfg_pkg::*;
    import conv_data_pkg::*;

    // sum_a is the W8 value or W1 sub-channel 0
    typedef struct packed {
        quant_mode_t mode;
        logic [24:0] sum_a;
        logic [12:0] sum_b;
        tail_set_t   tail;
        rank_set_t   rank;
    } add_stage_t;

    typedef struct packed {
        quant_mode_t mode;
        logic [41:0] prod_a;
        logic [29:0] prod_b;
        rank_set_t   rank;
    } mul_stage_t;

    logic       s1_vld;
    logic       s2_vld;
    add_stage_t s1_d;
    add_stage_t s1_q;
    mul_stage_t s2_d;
    mul_stage_t s2_q;
    logic [7:0] sat_a;
    logic [7:0] sat_b;

    // add half LSB, arithmetic shift, clamp to -128..127
    function automatic logic [7:0] round_shift_sat(
        input logic [41:0] prod,
        input logic [4:0]  sh
    );
        logic signed [42:0] rnd;
        logic signed [42:0] acc;
        rnd = '0;
        if (sh != 5'd0) begin
            rnd[sh - 5'd1] = 1'b1;
        end
        acc = $signed({prod[41], prod}) + rnd;
        acc = acc >>> sh;
        if (acc > 43'sd127) begin
            return 8'h7f;
        end
        if (acc < -43'sd128) begin
            return 8'h80;
        end
        return acc[7:0];
    endfunction

    //////////////////////////////
    // stage 1 bias add
    //////////////////////////////

    always_comb begin
        s1_d.mode = mode;
        s1_d.tail = param.tail;
        s1_d.rank = param.rank;
        // upper half only matters in W1
        s1_d.sum_b = $signed(psum[23:12]) + $signed(param.bias[15:8]);
        if (mode == MODE_W1) begin
            s1_d.sum_a = $signed(psum[11:0]) + $signed(param.bias[7:0]);
        end else begin
            s1_d.sum_a = $signed(psum) + $signed(param.bias);
        end
    end

    //////////////////////////////
    // stage 2 scale multiply
    //////////////////////////////

    // wide one takes W8 and sub-channel 0, tail is zero extended
    assign s2_d.mode   = s1_q.mode;
    assign s2_d.rank   = s1_q.rank;
    assign s2_d.prod_a = $signed(s1_q.sum_a) * $signed({1'b0, s1_q.tail[15:0]});
    assign s2_d.prod_b = $signed(s1_q.sum_b) * $signed({1'b0, s1_q.tail[31:16]});

    //////////////////////////////
    // stage 3 shift and clamp
    //////////////////////////////

    assign sat_a = round_shift_sat(s2_q.prod_a, s2_q.rank[4:0]);
    assign sat_b = round_shift_sat({{12{s2_q.prod_b[29]}}, s2_q.prod_b}, s2_q.rank[12:8]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
        end else begin
            s1_vld <= in_valid;
            s2_vld <= s1_vld;
        end
    end

    // output valid comes from the sequencer tags
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_q <= s1_d;
        end
        if (s1_vld) begin
            s2_q <= s2_d;
        end
        if (s2_vld) begin
            qpix <= (s2_q.mode == MODE_W1) ? {sat_b, sat_a} : {8'h00, sat_a};
        end
    end

endmodule

// File: source/row_sequencer.sv
`timescale 1ns/1ns
`include "conv_defines.svh"

module row_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  conv_cfg_pkg::tile_cfg_t   cfg,
    input  logic                      psum_valid,
    output logic                      load,
    output logic                      row_accept,
    output conv_cfg_pkg::chan_idx_t   cur_chan,
    output conv_cfg_pkg::quant_mode_t mode,
    output logic                      out_tag_valid,
    output conv_cfg_pkg::row_idx_t    out_row_idx,
    output conv_cfg_pkg::chan_idx_t   out_chan,
    output logic                      busy,
    output logic                      done
);

    import conv_cfg_pkg::*;

    // travels beside the lane pipeline
    typedef struct packed {
        logic      last;
        row_idx_t  row;
        chan_idx_t chan;
    } row_tag_t;

    seq_state_t      state;
    tile_cfg_t       cfg_q;
    row_idx_t        row_cnt;
    logic            last_row;
    row_tag_t        tag_in;
    logic [2:0]      tag_vld;
    row_tag_t [2:0]  tag_q;

    // start only counts when idle, tiles go with it
    assign load = start && (state == SEQ_IDLE);

    // RUN is left on the last row, so no count check needed here
    assign row_accept = psum_valid && (state == SEQ_RUN);

    assign last_row = (row_cnt == cfg_q.row_count - 1'b1);

    //////////////////////////////
    // control FSM
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= SEQ_IDLE;
            cfg_q    <= '0;
            row_cnt  <= '0;
            cur_chan <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (load) begin
                        cfg_q    <= cfg;
                        row_cnt  <= '0;
                        cur_chan <= '0;
                        state    <= SEQ_RUN;
                    end
                end
                SEQ_RUN: begin
                    if (row_accept) begin
                        row_cnt <= row_cnt + 1'b1;
                        // channel k mod CONV_CHANNELS
                        if (cur_chan == chan_idx_t'(`CONV_CHANNELS - 1)) begin
                            cur_chan <= '0;
                        end else begin
                            cur_chan <= cur_chan + 1'b1;
                        end
                        if (last_row) begin
                            state <= SEQ_DRAIN;
                        end
                    end
                end
                // wait for the last row to leave the lanes
                SEQ_DRAIN: begin
                    if (done) begin
                        state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // tag pipe, 3 deep
    //////////////////////////////

    assign tag_in = '{last: last_row, row: row_cnt, chan: cur_chan};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_vld <= '0;
        end else begin
            tag_vld <= {tag_vld[1:0], row_accept};
        end
    end

    // payload follows its valid bit
    always_ff @(posedge clk) begin
        if (row_accept) begin
            tag_q[0] <= tag_in;
        end
        if (tag_vld[0]) begin
            tag_q[1] <= tag_q[0];
        end
        if (tag_vld[1]) begin
            tag_q[2] <= tag_q[1];
        end
    end

    assign out_tag_valid = tag_vld[2];
    assign out_row_idx   = tag_q[2].row;
    assign out_chan      = tag_q[2].chan;

    // same cycle as the last output row
    assign done = tag_vld[2] && tag_q[2].last;
    assign busy = (state != SEQ_IDLE);
    assign mode = cfg_q.mode;

endmodule

// File: tb/conv_ref_model.svh
`ifndef CONV_REF_MODEL_SVH
`define CONV_REF_MODEL_SVH

//////////////////////////////
// requantization reference
//////////////////////////////

// needs conv_cfg_pkg, conv_data_pkg and conv_defines.svh in scope

// y = sat8(((x + b) * t + round) >>> r)
function automatic logic [7:0] ref_value(
    input longint x,
    input longint b,
    input longint t,
    input int     r
);
    longint acc;
    acc = (x + b) * t;
    // half an output LSB, only when there is a shift
    if (r > 0) begin
        acc = acc + (longint'(1) << (r - 1));
    end
    acc = acc >>> r;
    if (acc > 127) begin
        acc = 127;
    end else if (acc < -128) begin
        acc = -128;
    end
    return acc[7:0];
endfunction

// one lane, W8 in the low byte or two W1 sub-channels
function automatic qpix_lane_t ref_lane(
    input quant_mode_t  m,
    input psum_lane_t   x,
    input quant_param_t p
);
    logic [7:0] lo;
    logic [7:0] hi;
    if (m == MODE_W8) begin
        lo = ref_value(longint'($signed(x)), longint'($signed(p.bias)),
                       longint'(p.tail[15:0]), int'(p.rank[4:0]));
        hi = 8'h00;
    end else begin
        // sub-channel i takes half i of every field
        lo = ref_value(longint'($signed(x[11:0])), longint'($signed(p.bias[7:0])),
                       longint'(p.tail[15:0]), int'(p.rank[4:0]));
        hi = ref_value(longint'($signed(x[23:12])), longint'($signed(p.bias[15:8])),
                       longint'(p.tail[31:16]), int'(p.rank[12:8]));
    end
    return {hi, lo};
endfunction

// whole row, all lanes on one channel's set
function automatic qpix_row_t ref_row(
    input quant_mode_t  m,
    input psum_row_t    x,
    input quant_param_t p
);
    qpix_row_t pix;
    int        i;
    for (i = 0; i < `CONV_LANES; i++) begin
        pix[i] = ref_lane(m, x[i], p);
    end
    return pix;
endfunction

`endif

// File: tb/conv_datapath_tb.sv
`timescale 1ns/1ns
`include "conv_defines.svh"

module conv_datapath_tb;

    import conv_cfg_pkg::*;
    import conv_data_pkg::*;

    `include "conv_ref_model.svh"

    // all tests take under 200 cycles, the rest is margin
    localparam int MAX_CYCLES = 2000;
    // from the cycle a row is presented to its out_valid
    localparam int LATENCY = 3;

    typedef struct packed {
        out_row_t row;
        logic     last;
        int       due;
    } exp_entry_t;

    logic       clk;
    logic       rst_n;
    logic       start;
    tile_cfg_t  cfg;
    bias_tile_t bias_tile;
    tail_tile_t tail_tile;
    rank_tile_t rank_tile;
    logic       psum_valid;
    psum_row_t  psum_row;
    logic       out_valid;
    out_row_t   out_row;
    logic       busy;
    logic       done;

    // tile the DUT should be working on
    quant_mode_t act_mode;
    row_idx_t    act_rows;
    row_idx_t    next_row;
    bias_tile_t  act_bias;
    tail_tile_t  act_tail;
    rank_tile_t  act_rank;
    // tiles sent with the next start
    bias_tile_t  new_bias;
    tail_tile_t  new_tail;
    rank_tile_t  new_rank;

    exp_entry_t  exp_q[$];
    integer      seed;
    int          cyc;
    logic        busy_fall_due;

    conv_datapath u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .cfg        (cfg),
        .bias_tile  (bias_tile),
        .tail_tile  (tail_tile),
        .rank_tile  (rank_tile),
        .psum_valid (psum_valid),
        .psum_row   (psum_row),
        .out_valid  (out_valid),
        .out_row    (out_row),
        .busy       (busy),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_out_row(input out_row_t got, input out_row_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: out row %0d/%0d pix %h, expected %0d/%0d pix %h",
                     $time, got.row, got.chan, got.pix, exp.row, exp.chan, exp.pix);
            $display("CHECKS FAILED");
            $fatal(1, "output row mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    //////////////////////////////
    // output monitor
    //////////////////////////////

    // negedge, away from the driving edge
    always @(negedge clk) begin
        exp_entry_t head;
        cyc = cyc + 1;
        if (cyc > MAX_CYCLES) begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
        if (busy_fall_due) begin
            check_flag(busy, 1'b0, "busy after done");
        end
        busy_fall_due = 1'b0;
        if (out_valid && exp_q.size() == 0) begin
            $display("out_valid at %0t ns while no row was expected", $time);
            $display("CHECKS FAILED");
            $fatal(1, "unexpected output");
        end else if (out_valid) begin
            head = exp_q.pop_front();
            check_flag(cyc == head.due, 1'b1, "out_valid timing");
            check_out_row(out_row, head.row);
            check_flag(done, head.last, "done");
            check_flag(busy, 1'b1, "busy with output");
            busy_fall_due = head.last;
        end else begin
            check_flag(done, 1'b0, "done without output");
        end
    end

    //////////////////////////////
    // drivers
    //////////////////////////////

    task automatic apply_reset();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            psum_valid <= 1'b0;
        end
    endtask

    function automatic psum_row_t random_row();
        psum_row_t p;
        int        i;
        for (i = 0; i < `CONV_LANES; i++) begin
            p[i] = psum_lane_t'($random(seed));
        end
        return p;
    endfunction

    task automatic make_tiles();
        int c;
        for (c = 0; c < `CONV_CHANNELS; c++) begin
            new_bias[c] = bias_set_t'($random(seed));
            new_tail[c] = tail_set_t'($random(seed));
            // shift 0..31 per byte
            new_rank[c] = rank_set_t'($random(seed)) & 16'h1f1f;
        end
        // both ends of the shift range
        new_rank[0]                  = 16'h0000;
        new_rank[`CONV_CHANNELS - 1] = 16'h1f1f;
    endtask

    // taken means the DUT is idle and must accept this start
    task automatic load_tile(input quant_mode_t m, input row_idx_t rows, input logic taken);
        @(posedge clk);
        start      <= 1'b1;
        cfg        <= '{mode: m, row_count: rows};
        bias_tile  <= new_bias;
        tail_tile  <= new_tail;
        rank_tile  <= new_rank;
        psum_valid <= 1'b0;
        @(negedge clk);
        check_flag(busy, !taken, "busy while start is sampled");
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_flag(busy, 1'b1, "busy after start");
        if (taken) begin
            act_mode = m;
            act_rows = rows;
            act_bias = new_bias;
            act_tail = new_tail;
            act_rank = new_rank;
            next_row = '0;
        end
    endtask

    task automatic drive_row(input psum_row_t p);
        @(posedge clk);
        psum_valid <= 1'b1;
        psum_row   <= p;
    endtask

    // same time step as the drive_row it belongs to
    task automatic expect_row(input qpix_row_t pix);
        exp_entry_t e;
        e.row  = '{row: next_row, chan: chan_idx_t'(next_row % `CONV_CHANNELS), pix: pix};
        e.last = (next_row == act_rows - 1'b1);
        e.due  = cyc + 1 + LATENCY;
        exp_q.push_back(e);
        next_row = next_row + 1'b1;
    endtask

    task automatic send_row(input psum_row_t p);
        quant_param_t prm;
        chan_idx_t    ch;
        ch  = chan_idx_t'(next_row % `CONV_CHANNELS);
        prm = '{bias: act_bias[ch], tail: act_tail[ch], rank: act_rank[ch]};
        drive_row(p);
        expect_row(ref_row(act_mode, p, prm));
    endtask

    task automatic drain_tile();
        idle_cycles(1);
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic test_reset_idle();
        @(negedge clk);
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(done, 1'b0, "done after reset");
        check_flag(out_valid, 1'b0, "out_valid after reset");
        // no start yet, must not produce anything
        drive_row(random_row());
        idle_cycles(6);
    endtask

    task automatic test_mode_random(input quant_mode_t m, input int rows);
        int r;
        make_tiles();
        load_tile(m, row_idx_t'(rows), 1'b1);
        for (r = 0; r < rows; r++) begin
            send_row(random_row());
            // gaps of 0..2 cycles
            idle_cycles(r % 3);
        end
        drain_tile();
    endtask

    task automatic test_saturation();
        int c;
        for (c = 0; c < `CONV_CHANNELS; c++) begin
            new_bias[c] = 16'h0000;
            new_tail[c] = 32'hffff_ffff;
            new_rank[c] = 16'h0303;
        end
        load_tile(MODE_W8, 8'd2, 1'b1);
        drive_row({`CONV_LANES{24'h7fffff}});
        expect_row({`CONV_LANES{16'h007f}});
        drive_row({`CONV_LANES{24'h800000}});
        expect_row({`CONV_LANES{16'h0080}});
        drain_tile();
        // high half positive, low half negative, then swapped
        load_tile(MODE_W1, 8'd2, 1'b1);
        drive_row({`CONV_LANES{24'h7ff800}});
        expect_row({`CONV_LANES{16'h7f80}});
        drive_row({`CONV_LANES{24'h8007ff}});
        expect_row({`CONV_LANES{16'h807f}});
        drain_tile();
    endtask

    task automatic test_back_to_back();
        make_tiles();
        load_tile(MODE_W8, 8'd6, 1'b1);
        repeat (6) send_row(random_row());
        drain_tile();
    endtask

    task automatic test_ignored_start();
        make_tiles();
        load_tile(MODE_W8, 8'd4, 1'b1);
        send_row(random_row());
        send_row(random_row());
        // different mode and tiles while busy
        make_tiles();
        load_tile(MODE_W1, 8'd3, 1'b0);
        send_row(random_row());
        send_row(random_row());
        // one row past row_count
        drive_row(random_row());
        drain_tile();
        // idle again, same start now goes through
        load_tile(MODE_W1, 8'd3, 1'b1);
        repeat (3) send_row(random_row());
        drain_tile();
    endtask

    initial begin
        seed          = 40202;
        cyc           = 0;
        busy_fall_due = 1'b0;
        act_mode      = MODE_W8;
        act_rows      = '0;
        next_row      = '0;
        act_bias      = '0;
        act_tail      = '0;
        act_rank      = '0;
        rst_n         = 1'b0;
        start         = 1'b0;
        cfg           = '0;
        bias_tile     = '0;
        tail_tile     = '0;
        rank_tile     = '0;
        psum_valid    = 1'b0;
        psum_row      = '0;
        apply_reset();
        test_reset_idle();
        test_mode_random(MODE_W8, 10);
        test_mode_random(MODE_W1, 12);
        test_saturation();
        test_back_to_back();
        test_ignored_start();
        idle_cycles(4);
        if (exp_q.size() != 0) begin
            $display("%0d expected output rows never arrived", exp_q.size());
            $display("CHECKS FAILED");
            $fatal(1, "missing output rows");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule
